// File: dv/s16_main_tests.svh
// directed tests for the System 16A main CPU glue
// expected words come from the memory map and cabinet wiring rules

    // standard board wiring, output bit 7 first
    function automatic logic [7:0] sorted_joy(input logic [7:0] j);
        logic [7:0] r;
        r[7] = j[1];
        r[6] = j[0];
        r[5] = j[3];
        r[4] = j[2];
        r[3] = j[7];
        r[2] = j[5];
        r[1] = j[4];
        r[0] = j[6];
        return r;
    endfunction

    function automatic logic [7:0] pass_order_joy(input logic [7:0] j);
        logic [7:0] r;
        r    = j;     // upper nibble passes straight
        r[3] = j[1];
        r[2] = j[0];
        r[1] = j[3];
        r[0] = j[2];
        return r;
    endfunction

    function automatic logic [7:0] coin_word(input cab_in_t c, input logic pass);
        logic [7:0] r;
        r = {2'b11, c.start[1], c.start[0], c.service, c.dip_test, c.coin[1], c.coin[0]};
        if (pass) begin
            r[7:6] = c.start[3:2];  // players 3 and 4
        end
        return r;
    endfunction

    task automatic fill_mem_data();
        logic [95:0] bits;
        bits      = {next_random(), next_random(), next_random()};
        rom_data  = bits[15:0];
        ram_data  = bits[31:16];
        char_dout = bits[47:32];
        pal_dout  = bits[63:48];
        obj_dout  = bits[79:64];
    endtask

    task automatic load_random_cab();
        logic [95:0] bits;
        bits = {next_random(), next_random(), next_random()};
        cab  = bits[$bits(cab_in_t)-1:0];
    endtask

    task automatic mem_read_check(input logic [23:0] byte_addr, input chip_sel_t exp_sel,
                                  input logic [15:0] exp_data);
        logic [15:0] data;
        chip_sel_t   s;
        logic        be;
        bus_read(byte_addr, 3'b110, data, s, be);
        check_value($sformatf("sel @%h", byte_addr), s, exp_sel);
        check_value($sformatf("berr_n @%h", byte_addr), be, 1'b1);
        check_value($sformatf("cpu_din @%h", byte_addr), data, exp_data);
    endtask

    // I/O is 8 bit, upper byte floats high
    task automatic io_read_check(input logic [23:0] byte_addr, input logic [7:0] exp_byte);
        logic [15:0] data;
        chip_sel_t   s;
        logic        be;
        bus_read(byte_addr, 3'b101, data, s, be);
        check_value($sformatf("sel.io @%h", byte_addr), s.io, 1'b1);
        check_value($sformatf("cpu_din @%h", byte_addr), data, {8'hff, exp_byte});
    endtask

    task automatic reset_state_test();
        check_value("sel", sel, 8'h00);
        check_value("berr_n", berr_n, 1'b1);
        check_value("ipl_n", ipl_n, 3'b111);
        check_value("cpu_din", cpu_din, 16'hffff);
    endtask

    task automatic memory_map_test();
        chip_sel_t   exp;
        logic [15:0] data;
        chip_sel_t   s;
        logic        be;
        fill_mem_data();
        exp     = '0;
        exp.rom = 1'b1;
        mem_read_check(24'h001000, exp, rom_data);
        exp     = '0;
        exp.chr = 1'b1;
        mem_read_check(24'h410000, exp, char_dout);
        exp     = '0;
        exp.obj = 1'b1;
        mem_read_check(24'h440000, exp, obj_dout);
        exp     = '0;
        exp.pal = 1'b1;
        mem_read_check(24'h840000, exp, pal_dout);
        exp      = '0;
        exp.vram = 1'b1;
        mem_read_check(24'h400000, exp, ram_data); // vram shares the ram port
        exp     = '0;
        exp.ram = 1'b1;
        mem_read_check(24'hc70000, exp, ram_data);
        bus_read(24'h800000, 3'b110, data, s, be);   // hole in the 80 region
        check_value("berr_n @800000", be, 1'b0);
        check_value("sel @800000", s, 8'h00);
        check_value("cpu_din @800000", data, 16'hffff);
    endtask

    task automatic standard_cab_test();
        game_id = 8'h20;
        load_random_cab();
        io_read_check(24'hc41000, coin_word(cab, 1'b0));
        io_read_check(24'hc41002, sorted_joy(cab.joy1));
        io_read_check(24'hc41006, sorted_joy(cab.joy2));
        io_read_check(24'hc41004, 8'hff);  // reg 2 unused
        io_read_check(24'hc42000, cab.dipsw_a);
        io_read_check(24'hc42002, cab.dipsw_b);
        io_read_check(24'hc40000, 8'hff);  // PPI not fitted
    endtask

    task automatic passing_shot_test();
        logic [7:0] order [5];
        game_id = GAME_PASSSHT;
        load_random_cab();
        io_read_check(24'hc41000, coin_word(cab, 1'b1));
        // port counter wraps after the fourth player
        order = '{cab.joy1, cab.joy2, cab.joy3, cab.joy4, cab.joy1};
        for (int i = 0; i < 5; i++) begin
            io_read_check(24'hc41002, pass_order_joy(order[i]));
        end
    endtask

    task automatic interrupt_test();
        logic [15:0] data;
        chip_sel_t   s;
        logic        be;
        int          waited;
        check_value("ipl_n before vint", ipl_n, 3'b111);
        vint   = 1'b1;
        waited = 0;
        while (ipl_n != 3'b011 && waited < 3) begin
            @(negedge clk);
            waited++;
        end
        check_value("ipl_n after vint", ipl_n, 3'b011);
        bus_read(24'h001000, 3'b110, data, s, be);  // plain program fetch
        check_value("ipl_n after read", ipl_n, 3'b011);
        bus_read(24'hfffff8, 3'b111, data, s, be);  // level 4 acknowledge
        check_value("ipl_n after ack", ipl_n, 3'b111);
        vint = 1'b0;
        @(negedge clk);
    endtask

// File: dv/s16_main_tb.sv
// testbench for the System 16A main CPU glue
// plays the 68000 side with directed reads and a vblank interrupt
`timescale 1ns/1ps

module s16_main_tb
    import s16_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int ACCESS_CYCLES = 7;  // five held, two idle
    localparam int NUM_ACCESSES  = 22;
    localparam int TEST_CYCLES   = RESET_CYCLES + NUM_ACCESSES * ACCESS_CYCLES + 16;

    logic        clk;
    logic        rst;
    cpu_bus_t    cpu;
    logic [15:0] cpu_din;
    logic        berr_n;
    logic [2:0]  ipl_n;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    cab_in_t     cab;
    logic [7:0]  game_id;
    logic        vint;
    chip_sel_t   sel;
    logic [31:0] lcg_state;

    s16_main_bus uut (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .cpu_din   (cpu_din),
        .berr_n    (berr_n),
        .ipl_n     (ipl_n),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab       (cab),
        .game_id   (game_id),
        .vint      (vint),
        .sel       (sel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one 68000 read, entered and left on a falling edge
    task automatic bus_read(input logic [23:0] byte_addr, input logic [2:0] fc,
                            output logic [15:0] data, output chip_sel_t s,
                            output logic be);
        cpu.addr  = byte_addr[23:1];
        cpu.fc    = fc;
        cpu.rnw   = 1'b1;
        cpu.as_n  = 1'b0;
        cpu.uds_n = 1'b0;
        cpu.lds_n = 1'b0;
        repeat (5) @(negedge clk);
        data = cpu_din;
        s    = sel;
        be   = berr_n;
        cpu.as_n  = 1'b1;
        cpu.uds_n = 1'b1;
        cpu.lds_n = 1'b1;
        repeat (2) @(negedge clk);   // bus idle between accesses
    endtask

    `include "s16_main_tests.svh"

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cpu.addr  = '0;
        cpu.as_n  = 1'b1;
        cpu.uds_n = 1'b1;
        cpu.lds_n = 1'b1;
        cpu.rnw   = 1'b1;
        cpu.fc    = 3'd0;
        rom_data  = 16'h0000;
        ram_data  = 16'h0000;
        char_dout = 16'h0000;
        pal_dout  = 16'h0000;
        obj_dout  = 16'h0000;
        cab       = '0;
        game_id   = 8'h00;
        vint      = 1'b0;
        lcg_state = 32'hdc4d7a6e;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_state_test();
        memory_map_test();
        standard_cab_test();
        passing_shot_test();
        interrupt_test();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hw/s16_addr_decode.sv
// System 16A memory map decoder
// registers one chip select per window while AS is low, bus error otherwise
`timescale 1ns/1ps

module s16_addr_decode
    import s16_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  cpu,
    output chip_sel_t sel,
    output logic      berr_n
);

    logic [1:0] region;
    logic [2:0] bank;
    logic       ds;       // any data strobe active
    logic       vram_win;
    logic       ram_win;
    logic       hit;
    chip_sel_t  win;

    assign region = cpu.addr.map.region;
    assign bank   = cpu.addr.map.bank;
    assign ds     = ~(cpu.uds_n & cpu.lds_n);

    assign vram_win = region[0] && bank == BANK_VRAM;      // 40
    assign ram_win  = region == REGION_C && bank == BANK_RAM; // c7

    always_comb begin
        win      = '0;
        win.rom  = region == REGION_ROM && !bank[2];        // 00-03
        win.chr  = region[0] && bank == BANK_CHAR;          // 41
        win.obj  = region == REGION_41_44 && bank[2];       // 44
        win.pal  = region == REGION_84 && bank[2];          // 84
        win.io   = region == REGION_C &&
                   (bank == BANK_IO_LO || bank == BANK_IO_HI); // c4-c5
        win.wdog = region == REGION_C && bank == BANK_WDOG; // c6
        win.vram = vram_win && ds;
        win.ram  = ram_win && ds;
    end

    // a window hit counts even before the strobes arrive on a write
    assign hit = |{win.rom, win.chr, win.obj, win.pal, win.io, win.wdog,
                   vram_win, ram_win};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel    <= '0;
            berr_n <= 1'b1;
        end else if (!cpu.as_n) begin
            sel    <= win;
            berr_n <= hit;
        end else begin
            sel    <= '0;
            berr_n <= 1'b1;
        end
    end

endmodule

// File: hw/s16_cab_io.sv
// System 16A cabinet inputs
// coin/start word, sorted joysticks, DIP switches and the Passing Shot port counter
`timescale 1ns/1ps

module s16_cab_io
    import s16_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       io_cs,
    input  cpu_addr_u  addr,
    input  logic [7:0] game_id,
    input  cab_in_t    cab,
    output logic [7:0] cab_dout
);

    logic       io_cs_q;
    logic       io_rise;   // start of a new I/O access
    logic       pass_game;
    logic [1:0] port_cnt;
    logic [1:0] cnt_adv;
    logic [1:0] pass_sel;  // port shown on this access
    logic [1:0] slot;
    logic [1:0] io_reg;
    logic [7:0] pass_joy_sel;
    logic [7:0] rd_byte;

    // board wiring of the joystick bits on standard games
    function automatic logic [7:0] sort_joy(input logic [7:0] j);
        sort_joy = {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic logic [7:0] pass_joy(input logic [7:0] j);
        pass_joy = {j[7:4], j[1], j[0], j[3], j[2]};
    endfunction

    assign slot    = addr.io.io_slot;
    assign io_reg  = addr.io.io_reg;
    assign io_rise = io_cs & ~io_cs_q;

    assign pass_game = game_id == GAME_PASSSHT  ||
                       game_id == GAME_PASSSHT2 ||
                       game_id == GAME_PASSSHT3;

    assign cnt_adv  = port_cnt + 2'd1;
    assign pass_sel = io_rise ? cnt_adv : port_cnt; // advance before reading

    always_comb begin
        case (pass_sel)
            2'd1:    pass_joy_sel = pass_joy(cab.joy1);
            2'd2:    pass_joy_sel = pass_joy(cab.joy2);
            2'd3:    pass_joy_sel = pass_joy(cab.joy3);
            default: pass_joy_sel = pass_joy(cab.joy4);
        endcase
    end

    always_comb begin
        rd_byte = CAB_IDLE_BYTE;
        case (slot)
            IO_SLOT_PPI: rd_byte = CAB_IDLE_BYTE; // no 8255 fitted
            IO_SLOT_CAB: begin
                case (io_reg)
                    2'd0: begin
                        rd_byte = {2'b11, cab.start[1:0], cab.service, cab.dip_test,
                                   cab.coin};
                        if (pass_game) begin
                            rd_byte[7:6] = cab.start[3:2]; // players 3 and 4
                        end
                    end
                    2'd1:    rd_byte = pass_game ? pass_joy_sel : sort_joy(cab.joy1);
                    2'd3:    rd_byte = sort_joy(cab.joy2);
                    default: rd_byte = CAB_IDLE_BYTE;
                endcase
            end
            IO_SLOT_DIP: rd_byte = io_reg[0] ? cab.dipsw_b : cab.dipsw_a;
            default:     rd_byte = CAB_IDLE_BYTE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_cs_q  <= 1'b0;
            port_cnt <= 2'd0;
        end else begin
            io_cs_q <= io_cs;
            if (io_rise && pass_game && slot == IO_SLOT_CAB) begin
                if (io_reg == 2'd0) begin
                    port_cnt <= 2'd0;    // coin read restarts the scan
                end else if (io_reg == 2'd1) begin
                    port_cnt <= cnt_adv;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= CAB_IDLE_BYTE;
        end else begin
            cab_dout <= io_cs ? rd_byte : CAB_IDLE_BYTE;
        end
    end

endmodule

// File: hw/s16_data_mux.sv
// read data selection toward the main CPU
// registered, fixed priority over the chip selects
`timescale 1ns/1ps

module s16_data_mux
    import s16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  chip_sel_t   sel,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [7:0]  cab_dout,
    output logic [15:0] cpu_din
);

    logic [15:0] rd_word;

    always_comb begin
        if (sel.ram || sel.vram) begin
            rd_word = ram_data;          // work RAM and VRAM share one port
        end else if (sel.rom) begin
            rd_word = rom_data;
        end else if (sel.chr) begin
            rd_word = char_dout;
        end else if (sel.pal) begin
            rd_word = pal_dout;
        end else if (sel.obj) begin
            rd_word = obj_dout;
        end else if (sel.io) begin
            rd_word = {8'hff, cab_dout}; // 8-bit peripherals on the low byte
        end else begin
            rd_word = BUS_IDLE_WORD;     // watchdog and unmapped
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= BUS_IDLE_WORD;
        end else begin
            cpu_din <= rd_word;
        end
    end

endmodule

// File: hw/s16_irq_ctrl.sv
// vertical blank interrupt for the main CPU
// request on the vint rising edge, cleared by the acknowledge cycle
`timescale 1ns/1ps

module s16_irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic [2:0] fc,
    input  logic       as_n,
    output logic [2:0] ipl_n
);

    logic vint_q;
    logic vint_qq;
    logic vint_rise;
    logic inta;   // interrupt acknowledge cycle
    logic irq;

    assign vint_rise = vint_q & ~vint_qq;
    assign inta      = &fc & ~as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_q  <= 1'b0;
            vint_qq <= 1'b0;
            irq     <= 1'b0;
        end else begin
            vint_q  <= vint;
            vint_qq <= vint_q;
            if (inta) begin
                irq <= 1'b0;  // ack wins over a new edge
            end else if (vint_rise) begin
                irq <= 1'b1;
            end
        end
    end

    assign ipl_n = {~irq, 2'b11}; // lower lines unused

endmodule

// File: hw/s16_main_bus.sv
// System 16A main CPU glue top level
// address decoder, cabinet inputs, vblank interrupt and read data mux
`timescale 1ns/1ps

module s16_main_bus
    import s16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // 68000 side
    input  cpu_bus_t    cpu,
    output logic [15:0] cpu_din,
    output logic        berr_n,
    output logic [2:0]  ipl_n,
    // memory and video read data
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    // cabinet and control
    input  cab_in_t     cab,
    input  logic [7:0]  game_id,
    input  logic        vint,
    // memory enables
    output chip_sel_t   sel
);

    logic [7:0] cab_dout;

    s16_addr_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .cpu    (cpu),
        .sel    (sel),
        .berr_n (berr_n)
    );

    s16_cab_io u_cab (
        .clk      (clk),
        .rst      (rst),
        .io_cs    (sel.io),
        .addr     (cpu.addr),
        .game_id  (game_id),
        .cab      (cab),
        .cab_dout (cab_dout)
    );

    s16_irq_ctrl u_irq (
        .clk   (clk),
        .rst   (rst),
        .vint  (vint),
        .fc    (cpu.fc),
        .as_n  (cpu.as_n),
        .ipl_n (ipl_n)
    );

    s16_data_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .rom_data  (rom_data),  // no decryption on this board
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

endmodule

// File: hw/s16_pkg.sv
// System 16A main CPU glue definitions
// memory map codes, game ids, idle values and the bus, select and cabinet types
package s16_pkg;

    // address bits 23..22
    localparam logic [1:0] REGION_ROM   = 2'd0;
    localparam logic [1:0] REGION_41_44 = 2'd1;
    localparam logic [1:0] REGION_84    = 2'd2;
    localparam logic [1:0] REGION_C     = 2'd3;

    // address bits 18..16
    localparam logic [2:0] BANK_VRAM  = 3'd0;
    localparam logic [2:0] BANK_CHAR  = 3'd1;
    localparam logic [2:0] BANK_IO_LO = 3'd4;
    localparam logic [2:0] BANK_IO_HI = 3'd5;
    localparam logic [2:0] BANK_WDOG  = 3'd6;
    localparam logic [2:0] BANK_RAM   = 3'd7;

    // address bits 13..12 inside the I/O window
    localparam logic [1:0] IO_SLOT_PPI = 2'd0;
    localparam logic [1:0] IO_SLOT_CAB = 2'd1;
    localparam logic [1:0] IO_SLOT_DIP = 2'd2;

    // Passing Shot family, everything else is a standard cabinet
    localparam logic [7:0] GAME_PASSSHT  = 8'h01;
    localparam logic [7:0] GAME_PASSSHT2 = 8'h02;
    localparam logic [7:0] GAME_PASSSHT3 = 8'h03;

    localparam logic [15:0] BUS_IDLE_WORD = 16'hffff;
    localparam logic [7:0]  CAB_IDLE_BYTE = 8'hff;

    // memory map view of A[23:1]
    typedef struct packed {
        logic [1:0]  region; // A23..22
        logic [2:0]  mid;    // A21..19, not decoded
        logic [2:0]  bank;   // A18..16
        logic [14:0] low;    // A15..1
    } cpu_map_t;

    // I/O view of A[23:1]
    typedef struct packed {
        logic [9:0] hi_fill;  // A23..14
        logic [1:0] io_slot;  // A13..12
        logic [8:0] mid_fill; // A11..3
        logic [1:0] io_reg;   // A2..1
    } cpu_io_t;

    typedef union packed {
        cpu_map_t map;
        cpu_io_t  io;
    } cpu_addr_u;

    typedef struct packed {
        cpu_addr_u  addr;
        logic       as_n;
        logic       uds_n;
        logic       lds_n;
        logic       rnw;
        logic [2:0] fc;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic chr;
        logic obj;
        logic pal;
        logic io;
        logic wdog;
        logic vram;
        logic ram;
    } chip_sel_t;

    typedef struct packed {
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [7:0] joy3;
        logic [7:0] joy4;
        logic [3:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

endpackage

// File: sources.f
+incdir+dv
hw/s16_pkg.sv
hw/s16_addr_decode.sv
hw/s16_cab_io.sv
hw/s16_irq_ctrl.sv
hw/s16_data_mux.sv
hw/s16_main_bus.sv
dv/s16_main_tb.sv
